// ==== verilog/unix_time_pkg.sv ====
// Unix time conversion package
`default_nettype none

package unix_time_pkg;

	// ==============================
	// Field types
	// ==============================
	typedef logic [30:0] epoch_t;       // Seconds since 1970-01-01
	typedef logic [14:0] day_count_t;   // Whole days since the epoch
	typedef logic [16:0] sec_of_day_t;  // 0 .. 86399
	typedef logic [2:0]  weekday_t;     // 0 is Sunday
	typedef logic [10:0] year_t;
	typedef logic [3:0]  month_t;       // 1 .. 12
	typedef logic [4:0]  mday_t;        // 1 .. 31
	typedef logic [4:0]  hour_t;
	typedef logic [5:0]  minute_t;      // Also used for seconds
	typedef logic [3:0]  bcd_digit_t;
	typedef logic [10:0] cycle_day_t;   // Day within a four-year cycle
	typedef logic [8:0]  year_day_t;    // Zero-based day within a year

	typedef struct packed {
		year_t  year;
		month_t month;
		mday_t  mday;
	} civil_date_t;

	typedef struct packed {
		hour_t   hour;
		minute_t minute;
		minute_t second;
	} clock_fields_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		BUSY
	} serial_phase_t;

	// ==============================
	// Calendar constants
	// ==============================
	localparam int unsigned SECONDS_PER_DAY    = 86400;
	localparam int unsigned SECONDS_PER_HOUR   = 3600;
	localparam int unsigned SECONDS_PER_MINUTE = 60;
	localparam int unsigned DAYS_PER_WEEK      = 7;
	localparam int unsigned DAYS_PER_CYCLE     = 1461;  // 3 x 365 + 366
	localparam int unsigned MONTHS_PER_YEAR    = 12;
	localparam int unsigned EPOCH_YEAR         = 1970;
	localparam int unsigned EPOCH_WEEKDAY      = 4;     // Thursday
	localparam int unsigned DIGIT_COUNT        = 14;

	// 1972 is the third year of each cycle and the leap one
	localparam cycle_day_t CYCLE_YEAR_START [0:3] = '{11'd0, 11'd365, 11'd730, 11'd1096};

	localparam year_day_t MONTH_START_COMMON [0:MONTHS_PER_YEAR-1] = '{
		9'd0, 9'd31, 9'd59, 9'd90, 9'd120, 9'd151,
		9'd181, 9'd212, 9'd243, 9'd273, 9'd304, 9'd334
	};

	localparam year_day_t MONTH_START_LEAP [0:MONTHS_PER_YEAR-1] = '{
		9'd0, 9'd31, 9'd60, 9'd91, 9'd121, 9'd152,
		9'd182, 9'd213, 9'd244, 9'd274, 9'd305, 9'd335
	};

endpackage

`default_nettype wire

// ==== verilog/time_capture.sv ====
// Timestamp capture and start control
`timescale 1ns/1ps
`default_nettype none

module time_capture
	import unix_time_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  epoch_t in_time,
	input  logic   burst_done,
	output logic   start,
	output epoch_t stamp
);

	serial_phase_t phase;
	serial_phase_t phase_next;

	// ==============================
	// Input FSM
	// ==============================
	always_comb begin
		phase_next = phase;
		case (phase)
			IDLE:    if (in_valid) phase_next = LOAD;
			LOAD:    if (!in_valid) phase_next = BUSY;   // Falling edge of in_valid
			BUSY:    if (burst_done) phase_next = IDLE;
			default: phase_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= IDLE;
			start <= 1'b0;
		end else begin
			phase <= phase_next;
			start <= (phase == LOAD) && !in_valid;  // One cycle after edge E
		end
	end

	// Last value seen while in_valid is high wins
	always_ff @(posedge clk) begin
		if (in_valid && (phase != BUSY)) begin
			stamp <= in_time;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/epoch_splitter.sv ====
// Day and second-of-day split
`timescale 1ns/1ps
`default_nettype none

module epoch_splitter
	import unix_time_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  epoch_t      stamp,
	output logic        split_valid,
	output day_count_t  days,
	output sec_of_day_t sec_of_day,
	output weekday_t    weekday
);

	day_count_t  days_c;
	sec_of_day_t sec_c;
	weekday_t    weekday_c;

	always_comb begin
		days_c    = day_count_t'(stamp / SECONDS_PER_DAY);
		sec_c     = sec_of_day_t'(stamp % SECONDS_PER_DAY);
		weekday_c = weekday_t'((32'(days_c) + EPOCH_WEEKDAY) % DAYS_PER_WEEK);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			split_valid <= 1'b0;
		end else begin
			split_valid <= start;  // Edge E+1
		end
	end

	// Held until the next conversion starts
	always_ff @(posedge clk) begin
		if (start) begin
			days       <= days_c;
			sec_of_day <= sec_c;
			weekday    <= weekday_c;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/civil_date.sv ====
// Calendar date from day count
`timescale 1ns/1ps
`default_nettype none

module civil_date
	import unix_time_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        split_valid,
	input  day_count_t  days,
	output logic        date_valid,
	output civil_date_t date
);

	logic [4:0] cycle_idx;   // Whole four-year cycles, at most 17
	cycle_day_t cycle_day;
	logic [1:0] cycle_year;  // Year within the cycle
	logic       leap;
	year_day_t  year_day;
	year_day_t  month_base;  // First day of the found month
	month_t     month_idx;   // Zero-based month

	function automatic year_day_t month_start(input logic is_leap, input int m);
		return is_leap ? MONTH_START_LEAP[m] : MONTH_START_COMMON[m];
	endfunction

	// ==============================
	// Year and month search
	// ==============================
	always_comb begin
		cycle_idx  = 5'(days / DAYS_PER_CYCLE);
		cycle_day  = cycle_day_t'(days % DAYS_PER_CYCLE);

		cycle_year = 2'd0;
		for (int y = 1; y < 4; y++) begin
			if (cycle_day >= CYCLE_YEAR_START[y]) begin
				cycle_year = 2'(y);
			end
		end

		leap     = (cycle_year == 2'd2);  // 1972, 1976, ... 2036
		year_day = year_day_t'(cycle_day - CYCLE_YEAR_START[cycle_year]);

		// Last month whose start is not past the day
		month_idx  = '0;
		month_base = '0;
		for (int m = 0; m < MONTHS_PER_YEAR; m++) begin
			if (year_day >= month_start(leap, m)) begin
				month_idx  = month_t'(m);
				month_base = month_start(leap, m);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			date_valid <= 1'b0;
		end else begin
			date_valid <= split_valid;  // Edge E+2
		end
	end

	always_ff @(posedge clk) begin
		if (split_valid) begin
			date.year  <= year_t'(EPOCH_YEAR + 4 * cycle_idx + cycle_year);
			date.month <= month_idx + 4'd1;
			date.mday  <= mday_t'(year_day - month_base + 9'd1);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/clock_time.sv ====
// Hour, minute and second from seconds of day
`timescale 1ns/1ps
`default_nettype none

module clock_time
	import unix_time_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          split_valid,
	input  sec_of_day_t   sec_of_day,
	output clock_fields_t clock
);

	logic [11:0]   sec_of_hour;  // 0 .. 3599
	clock_fields_t clock_c;

	always_comb begin
		sec_of_hour    = 12'(sec_of_day % SECONDS_PER_HOUR);
		clock_c.hour   = hour_t'(sec_of_day / SECONDS_PER_HOUR);
		clock_c.minute = minute_t'(sec_of_hour / SECONDS_PER_MINUTE);
		clock_c.second = minute_t'(sec_of_hour % SECONDS_PER_MINUTE);
	end

	// Same edge as the date result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clock <= '0;
		end else if (split_valid) begin
			clock <= clock_c;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/digit_serializer.sv ====
// BCD conversion and serial digit output
`timescale 1ns/1ps
`default_nettype none

module digit_serializer
	import unix_time_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          date_valid,
	input  civil_date_t   date,
	input  clock_fields_t clock,
	input  weekday_t      weekday,
	output logic          out_valid,
	output bcd_digit_t    out_display,
	output weekday_t      out_day,
	output logic          burst_done
);

	logic [15:0] year_bcd;
	logic [15:0] month_bcd;
	logic [15:0] mday_bcd;
	logic [15:0] hour_bcd;
	logic [15:0] minute_bcd;
	logic [15:0] second_bcd;

	bcd_digit_t [DIGIT_COUNT-1:0] digits_c;  // Year thousands on top
	bcd_digit_t [DIGIT_COUNT-1:0] shift_q;
	logic [3:0]                   digit_cnt;  // Digits sent so far

	// Shift-and-add-3 over an 11-bit value, four digits
	function automatic logic [15:0] to_bcd(input logic [10:0] bin);
		logic [15:0] bcd;
		bcd = '0;
		for (int i = 10; i >= 0; i--) begin
			for (int d = 0; d < 4; d++) begin
				if (bcd[d*4 +: 4] > 4'd4) begin
					bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
				end
			end
			bcd = {bcd[14:0], bin[i]};
		end
		return bcd;
	endfunction

	always_comb begin
		year_bcd   = to_bcd(date.year);
		month_bcd  = to_bcd(11'(date.month));
		mday_bcd   = to_bcd(11'(date.mday));
		hour_bcd   = to_bcd(11'(clock.hour));
		minute_bcd = to_bcd(11'(clock.minute));
		second_bcd = to_bcd(11'(clock.second));
		digits_c   = {year_bcd, month_bcd[7:0], mday_bcd[7:0],
		              hour_bcd[7:0], minute_bcd[7:0], second_bcd[7:0]};
	end

	// ==============================
	// Burst control
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid   <= 1'b0;
			out_display <= '0;
			out_day     <= '0;
			digit_cnt   <= '0;
			burst_done  <= 1'b0;
		end else if (date_valid) begin
			out_valid   <= 1'b1;                      // Edge E+3
			out_display <= digits_c[DIGIT_COUNT-1];
			out_day     <= weekday;
			digit_cnt   <= 4'd1;
			burst_done  <= 1'b0;
		end else if (out_valid) begin
			if (digit_cnt == 4'(DIGIT_COUNT)) begin  // Burst over
				out_valid   <= 1'b0;
				out_display <= '0;
				out_day     <= '0;
				digit_cnt   <= '0;
				burst_done  <= 1'b0;
			end else begin
				out_display <= shift_q[DIGIT_COUNT-1];
				digit_cnt   <= digit_cnt + 4'd1;
				burst_done  <= (digit_cnt == 4'(DIGIT_COUNT - 1));  // With the last digit
			end
		end
	end

	// Remaining digits, top one goes out next
	always_ff @(posedge clk) begin
		if (date_valid) begin
			shift_q <= {digits_c[DIGIT_COUNT-2:0], bcd_digit_t'(0)};
		end else if (out_valid) begin
			shift_q <= {shift_q[DIGIT_COUNT-2:0], bcd_digit_t'(0)};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/unix_clock_top.sv ====
// Unix time to calendar converter
`timescale 1ns/1ps
`default_nettype none

module unix_clock_top
	import unix_time_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  epoch_t     in_time,
	output logic       out_valid,
	output bcd_digit_t out_display,
	output weekday_t   out_day
);

	logic          start;
	epoch_t        stamp;
	logic          split_valid;
	day_count_t    days;
	sec_of_day_t   sec_of_day;
	weekday_t      weekday;
	logic          date_valid;
	civil_date_t   date;
	clock_fields_t clock;
	logic          burst_done;

	// ==============================
	// Input side
	// ==============================
	time_capture u_time_capture (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_time    (in_time),
		.burst_done (burst_done),
		.start      (start),
		.stamp      (stamp)
	);

	// ==============================
	// Processing
	// ==============================
	epoch_splitter u_epoch_splitter (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.stamp       (stamp),
		.split_valid (split_valid),
		.days        (days),
		.sec_of_day  (sec_of_day),
		.weekday     (weekday)
	);

	civil_date u_civil_date (
		.clk         (clk),
		.rst_n       (rst_n),
		.split_valid (split_valid),
		.days        (days),
		.date_valid  (date_valid),
		.date        (date)
	);

	clock_time u_clock_time (
		.clk         (clk),
		.rst_n       (rst_n),
		.split_valid (split_valid),
		.sec_of_day  (sec_of_day),
		.clock       (clock)
	);

	// ==============================
	// Output side
	// ==============================
	digit_serializer u_digit_serializer (
		.clk         (clk),
		.rst_n       (rst_n),
		.date_valid  (date_valid),
		.date        (date),
		.clock       (clock),
		.weekday     (weekday),
		.out_valid   (out_valid),
		.out_display (out_display),
		.out_day     (out_day),
		.burst_done  (burst_done)
	);

endmodule

`default_nettype wire

// ==== sim/tb_unix_clock.sv ====
// Unix clock converter testbench
`timescale 1ns/1ps
`default_nettype none

module tb_unix_clock
	import unix_time_pkg::*;
();

	localparam int RANDOM_COUNT    = 200;
	localparam int CONVERSIONS     = RANDOM_COUNT + 5;
	localparam int WATCHDOG_CYCLES = CONVERSIONS * 40 + 300;
	localparam int START_LATENCY   = 4;   // Falling edges from in_valid low to edge E+3
	localparam int START_TIMEOUT   = 20;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	epoch_t     in_time;
	logic       out_valid;
	bcd_digit_t out_display;
	weekday_t   out_day;

	int         model_digits [DIGIT_COUNT];
	int         model_day;
	int         errors;
	int         checks;
	int         tests_run;
	int         test_first_error;
	logic       burst_expected;
	logic [4:0] valid_run;   // Consecutive out_valid cycles

	unix_clock_top dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_time     (in_time),
		.out_valid   (out_valid),
		.out_display (out_display),
		.out_day     (out_day)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	function automatic void report_error(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endfunction

	function automatic void check_equal(input int got, input int want, input string what);
		checks++;
		value_match: assert (got == want)
			else report_error($sformatf("%s: got %0d, expected %0d", what, got, want));
	endfunction

	function automatic void end_test(input string name);
		tests_run++;
		$display("Test %0d %s done, %0d errors", tests_run, name, errors - test_first_error);
		test_first_error = errors;
	endfunction

	// ==============================
	// Reference model
	// ==============================
	function automatic int year_length(input int year);
		return (year % 4 == 0) ? 366 : 365;  // 2000 is leap and no other century is in range
	endfunction

	function automatic int month_length(input int year, input int month);
		case (month)
			2:           return (year % 4 == 0) ? 29 : 28;
			4, 6, 9, 11: return 30;
			default:     return 31;
		endcase
	endfunction

	function automatic void put_decimal(input int pos, input int width, input int value);
		int v;
		v = value;
		for (int k = width - 1; k >= 0; k--) begin
			model_digits[pos + k] = v % 10;
			v = v / 10;
		end
	endfunction

	function automatic void compute_expected(input epoch_t stamp);
		int days;
		int secs;
		int year;
		int month;
		int day_left;
		days      = int'(stamp) / 86400;
		secs      = int'(stamp) % 86400;
		model_day = (days + 4) % 7;            // Epoch day was a Thursday
		year      = 1970 + 4 * (days / 1461);  // Whole four-year cycles
		day_left  = days % 1461;
		while (day_left >= year_length(year)) begin
			day_left -= year_length(year);
			year++;
		end
		month = 1;
		while (day_left >= month_length(year, month)) begin
			day_left -= month_length(year, month);
			month++;
		end
		put_decimal(0, 4, year);
		put_decimal(4, 2, month);
		put_decimal(6, 2, day_left + 1);
		put_decimal(8, 2, secs / 3600);
		put_decimal(10, 2, (secs % 3600) / 60);
		put_decimal(12, 2, secs % 60);
	endfunction

	// Model against a known calendar string
	function automatic void check_model(input epoch_t stamp, input string want, input int want_day);
		compute_expected(stamp);
		for (int i = 0; i < DIGIT_COUNT; i++) begin
			check_equal(model_digits[i], int'(want[i]) - 48, $sformatf("model digit %0d", i));
		end
		check_equal(model_day, want_day, "model weekday");
	endfunction

	// Holds in_valid for hold cycles with the stamp last and then checks the burst
	task automatic run_conversion(input epoch_t stamp, input int hold, input bit noisy);
		int waited;
		compute_expected(stamp);
		burst_expected = 1'b1;
		for (int i = 1; i <= hold; i++) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_time  = (i == hold) ? stamp : epoch_t'($urandom());
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_time  = epoch_t'($urandom());
		waited   = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!out_valid && waited < START_TIMEOUT);
		if (!out_valid) begin
			errors++;
			$display("No output burst within %0d cycles for stamp %0d", START_TIMEOUT, stamp);
		end else begin
			check_equal(waited, START_LATENCY, "cycles from in_valid low to first digit");
			for (int i = 0; i < DIGIT_COUNT; i++) begin
				if (i > 0) begin
					@(negedge clk);
					check_equal(int'(out_valid), 1, "out_valid during burst");
				end
				check_equal(int'(out_display), model_digits[i],
				            $sformatf("digit %0d of stamp %0d", i, stamp));
				check_equal(int'(out_day), model_day, $sformatf("weekday of stamp %0d", stamp));
				in_valid = noisy && (i == 2 || i == 6);  // Pulses while busy
				in_time  = epoch_t'($urandom());
			end
			@(negedge clk);
			check_equal(int'(out_valid), 0, "out_valid after the last digit");
		end
		in_valid       = 1'b0;
		burst_expected = 1'b0;
	endtask

	// ==============================
	// Output protocol checks
	// ==============================
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_run <= '0;
		end else begin
			valid_run <= out_valid ? valid_run + 5'd1 : 5'd0;
		end
	end

	idle_outputs_zero: assert property (@(posedge clk)
		!out_valid |-> (out_display == '0 && out_day == '0))
		else report_error("out_display or out_day not 0 while out_valid is low");

	burst_length: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_valid) |-> (valid_run == 5'(DIGIT_COUNT)))
		else report_error($sformatf("burst length %0d cycles", valid_run));

	day_held: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && $past(out_valid)) |-> (out_day == $past(out_day)))
		else report_error("out_day changed during a burst");

	no_extra_burst: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> burst_expected)
		else report_error("out_valid rose with no conversion requested");

	initial begin
		void'($urandom(78129));
		rst_n            = 1'b0;
		in_valid         = 1'b0;
		in_time          = '0;
		burst_expected   = 1'b0;
		errors           = 0;
		checks           = 0;
		tests_run        = 0;
		test_first_error = 0;

		for (int c = 0; c < 7; c++) begin
			@(negedge clk);
			rst_n = (c >= 3);  // Four cycles in reset
			check_equal(int'(out_valid), 0, "out_valid around reset");
			check_equal(int'(out_display), 0, "out_display around reset");
			check_equal(int'(out_day), 0, "out_day around reset");
		end
		end_test("reset");

		check_model(31'd0, "19700101000000", 4);
		run_conversion(31'd0, 1, 1'b0);
		end_test("epoch and timing");

		check_model(31'd951782400, "20000229000000", 2);
		run_conversion(31'd951782400, 1, 1'b0);
		check_model(31'd2147483647, "20380119031407", 2);
		run_conversion(31'd2147483647, 1, 1'b0);
		end_test("leap and range edges");

		repeat (RANDOM_COUNT) run_conversion(epoch_t'($urandom()), 1, 1'b0);
		end_test("random stamps");

		run_conversion(epoch_t'($urandom()), 5, 1'b0);
		run_conversion(epoch_t'($urandom()), 1, 1'b1);
		repeat (40) begin
			@(negedge clk);
			check_equal(int'(out_valid), 0, "out_valid with no conversion pending");
		end
		end_test("input rules");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/unix_time_pkg.sv
verilog/time_capture.sv
verilog/epoch_splitter.sv
verilog/civil_date.sv
verilog/clock_time.sv
verilog/digit_serializer.sv
verilog/unix_clock_top.sv
sim/tb_unix_clock.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the unix clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log
BUILD_DIR=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_unix_clock -Mdir "$BUILD_DIR" -o sim_unix_clock; then
	echo "Verilator build failed"
	exit 1
fi

if ! "./$BUILD_DIR/sim_unix_clock" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi
cat "$LOG"

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
